/* common/rename_macros.svh */
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// architectural register file
`define RN_ARCH_REGS 32
`define RN_REG_SEL 5

// rename register file, one tag per entry
`define RN_RRF_NUM 16
`define RN_RRF_SEL 4

// datapath
`define RN_DATA_LEN 32

// alu and load/store
`define RN_WB_PORTS 2

`endif

/* common/rename_pkg.sv */
`default_nettype none

`include "rename_macros.svh"

package rename_pkg;

    // one decoded instruction entering rename
    typedef struct packed {
        logic                   valid;
        logic [`RN_REG_SEL-1:0] rs1;
        logic [`RN_REG_SEL-1:0] rs2;
        logic [`RN_REG_SEL-1:0] rd;
        logic                   dst_en;
    } rename_req_t;

    typedef struct packed {
        logic                    valid;
        logic [`RN_RRF_SEL-1:0]  tag;
        logic [`RN_DATA_LEN-1:0] data;
    } wb_port_t;

    // in-order retire from the rob
    typedef struct packed {
        logic                   valid;
        logic                   we;
        logic [`RN_REG_SEL-1:0] rd;
        logic [`RN_RRF_SEL-1:0] tag;
    } commit_t;

    typedef struct packed {
        logic [`RN_DATA_LEN-`RN_RRF_SEL-1:0] pad;
        logic [`RN_RRF_SEL-1:0]              tag;
    } pend_tag_t;

    // value when ready, producer tag when not
    typedef union packed {
        logic [`RN_DATA_LEN-1:0] data;
        pend_tag_t               pend;
    } operand_u;

    typedef struct packed {
        operand_u word;
        logic     ready;
    } operand_t;

    typedef struct packed {
        logic                   valid;
        logic                   dst_en;
        logic [`RN_RRF_SEL-1:0] dst_tag;
        operand_t               src1;
        operand_t               src2;
    } rename_rsp_t;

endpackage

`default_nettype wire

/* rename/rename_arf.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module rename_arf (
    input  wire                      clk_i,
    input  wire                      reset_i,

    input  wire [`RN_REG_SEL-1:0]    rs1_i,
    input  wire [`RN_REG_SEL-1:0]    rs2_i,
    output wire [`RN_DATA_LEN-1:0]   rs1_data_o,
    output wire [`RN_DATA_LEN-1:0]   rs2_data_o,
    output wire                      rs1_busy_o,
    output wire                      rs2_busy_o,
    output wire [`RN_RRF_SEL-1:0]    rs1_tag_o,
    output wire [`RN_RRF_SEL-1:0]    rs2_tag_o,

    input  wire                      set_en_i,
    input  wire [`RN_REG_SEL-1:0]    set_rd_i,
    input  wire [`RN_RRF_SEL-1:0]    set_tag_i,

    input  wire rename_pkg::commit_t commit_i,
    input  wire [`RN_DATA_LEN-1:0]   commit_data_i
);

    logic [`RN_DATA_LEN-1:0]  data_q [`RN_ARCH_REGS];
    logic [`RN_RRF_SEL-1:0]   tag_q  [`RN_ARCH_REGS];
    logic [`RN_ARCH_REGS-1:0] busy_q;

    logic commit_wr;
    logic rename_wr;
    logic tag_match;

    // x0 is hardwired, never written or renamed
    assign commit_wr = commit_i.valid && commit_i.we && (commit_i.rd != '0);
    assign rename_wr = set_en_i && (set_rd_i != '0);

    // only the youngest producer may release the register
    assign tag_match = busy_q[commit_i.rd] && (tag_q[commit_i.rd] == commit_i.tag);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= '0;
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                data_q[i] <= '0;
                tag_q[i]  <= '0;
            end
        end else begin
            if (commit_wr) begin
                data_q[commit_i.rd] <= commit_data_i;
                if (tag_match) begin
                    busy_q[commit_i.rd] <= 1'b0;
                end
            end
            // rename after commit so a new mapping wins
            if (rename_wr) begin
                busy_q[set_rd_i] <= 1'b1;
                tag_q[set_rd_i]  <= set_tag_i;
            end
        end
    end

    assign rs1_data_o = data_q[rs1_i];
    assign rs2_data_o = data_q[rs2_i];
    assign rs1_busy_o = busy_q[rs1_i];
    assign rs2_busy_o = busy_q[rs2_i];
    assign rs1_tag_o  = tag_q[rs1_i];
    assign rs2_tag_o  = tag_q[rs2_i];

endmodule

`default_nettype wire

/* rename/rename_rrf.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module rename_rrf (
    input  wire                                         clk_i,
    input  wire                                         reset_i,

    input  wire [`RN_RRF_SEL-1:0]                       rs1_tag_i,
    input  wire [`RN_RRF_SEL-1:0]                       rs2_tag_i,
    output wire [`RN_DATA_LEN-1:0]                      rs1_data_o,
    output wire [`RN_DATA_LEN-1:0]                      rs2_data_o,
    output wire                                         rs1_valid_o,
    output wire                                         rs2_valid_o,

    input  wire rename_pkg::wb_port_t [`RN_WB_PORTS-1:0] wb_i,

    input  wire                                         alloc_en_i,
    input  wire [`RN_RRF_SEL-1:0]                       alloc_tag_i,

    input  wire [`RN_RRF_SEL-1:0]                       commit_tag_i,
    output wire [`RN_DATA_LEN-1:0]                      commit_data_o
);

    logic [`RN_DATA_LEN-1:0] data_q [`RN_RRF_NUM];
    logic [`RN_RRF_NUM-1:0]  valid_q;

    always_ff @(posedge clk_i) begin
        for (int p = 0; p < `RN_WB_PORTS; p++) begin
            if (wb_i[p].valid) begin
                data_q[wb_i[p].tag] <= wb_i[p].data;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else begin
            for (int p = 0; p < `RN_WB_PORTS; p++) begin
                if (wb_i[p].valid) begin
                    valid_q[wb_i[p].tag] <= 1'b1;
                end
            end
            // fresh entry, result not produced yet
            if (alloc_en_i) begin
                valid_q[alloc_tag_i] <= 1'b0;
            end
        end
    end

    assign rs1_data_o  = data_q[rs1_tag_i];
    assign rs2_data_o  = data_q[rs2_tag_i];
    assign rs1_valid_o = valid_q[rs1_tag_i];
    assign rs2_valid_o = valid_q[rs2_tag_i];

    assign commit_data_o = data_q[commit_tag_i];

endmodule

`default_nettype wire

/* rename/rrf_alloc.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module rrf_alloc (
    input  wire                   clk_i,
    input  wire                   reset_i,

    input  wire                   alloc_en_i,
    input  wire                   free_en_i,

    output wire [`RN_RRF_SEL-1:0] alloc_tag_o,
    output wire [`RN_RRF_SEL:0]   free_num_o,
    output wire                   stall_o
);

    logic [`RN_RRF_SEL-1:0] ptr_q;
    logic [`RN_RRF_SEL:0]   free_q;

    // pointer wraps naturally at the rrf depth
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ptr_q <= '0;
        end else if (alloc_en_i) begin
            ptr_q <= ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            free_q <= (`RN_RRF_SEL+1)'(`RN_RRF_NUM);
        end else begin
            case ({alloc_en_i, free_en_i})
                2'b10:   free_q <= free_q - 1'b1;
                2'b01:   free_q <= free_q + 1'b1;
                default: free_q <= free_q;
            endcase
        end
    end

    assign alloc_tag_o = ptr_q;
    assign free_num_o  = free_q;

    // no free entry left
    assign stall_o = (free_q == '0);

endmodule

`default_nettype wire

/* rename/src_resolve.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module src_resolve (
    input  wire [`RN_REG_SEL-1:0]  rs_i,

    input  wire                    arf_busy_i,
    input  wire [`RN_DATA_LEN-1:0] arf_data_i,
    input  wire [`RN_RRF_SEL-1:0]  arf_tag_i,

    input  wire                    rrf_valid_i,
    input  wire [`RN_DATA_LEN-1:0] rrf_data_i,

    output rename_pkg::operand_t   opnd_o
);

    always_comb begin
        opnd_o = '0;
        if (rs_i == '0) begin
            opnd_o.ready     = 1'b1;
            opnd_o.word.data = '0;
        end else if (!arf_busy_i) begin
            opnd_o.ready     = 1'b1;
            opnd_o.word.data = arf_data_i;
        end else if (rrf_valid_i) begin
            // result already written back, not yet retired
            opnd_o.ready     = 1'b1;
            opnd_o.word.data = rrf_data_i;
        end else begin
            // wait on the producer tag
            opnd_o.ready         = 1'b0;
            opnd_o.word.pend.tag = arf_tag_i;
        end
    end

endmodule

`default_nettype wire

/* rename/rename_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module rename_unit (
    input  wire                                         clk_i,
    input  wire                                         reset_i,

    input  wire rename_pkg::rename_req_t                req_i,
    input  wire rename_pkg::wb_port_t [`RN_WB_PORTS-1:0] wb_i,
    input  wire rename_pkg::commit_t                    commit_i,

    output rename_pkg::rename_rsp_t                     rsp_o,
    output wire                                         stall_o,
    output wire [`RN_RRF_SEL:0]                         free_num_o,
    output wire [`RN_RRF_SEL-1:0]                       rrf_ptr_o
);

    logic accept;
    logic alloc_en;

    logic [`RN_RRF_SEL-1:0]  alloc_tag;

    logic [`RN_DATA_LEN-1:0] rs1_arf_data;
    logic [`RN_DATA_LEN-1:0] rs2_arf_data;
    logic                    rs1_busy;
    logic                    rs2_busy;
    logic [`RN_RRF_SEL-1:0]  rs1_tag;
    logic [`RN_RRF_SEL-1:0]  rs2_tag;

    logic [`RN_DATA_LEN-1:0] rs1_rrf_data;
    logic [`RN_DATA_LEN-1:0] rs2_rrf_data;
    logic                    rs1_rrf_valid;
    logic                    rs2_rrf_valid;
    logic [`RN_DATA_LEN-1:0] commit_data;

    rename_pkg::operand_t    src1;
    rename_pkg::operand_t    src2;
    rename_pkg::rename_rsp_t rsp_q;

    // requests during stall are dropped, the sender holds them
    assign accept   = req_i.valid && !stall_o;
    assign alloc_en = accept && req_i.dst_en;

    rename_arf i_rename_arf (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .rs1_i        (req_i.rs1),
        .rs2_i        (req_i.rs2),
        .rs1_data_o   (rs1_arf_data),
        .rs2_data_o   (rs2_arf_data),
        .rs1_busy_o   (rs1_busy),
        .rs2_busy_o   (rs2_busy),
        .rs1_tag_o    (rs1_tag),
        .rs2_tag_o    (rs2_tag),
        .set_en_i     (alloc_en),
        .set_rd_i     (req_i.rd),
        .set_tag_i    (alloc_tag),
        .commit_i     (commit_i),
        .commit_data_i(commit_data)
    );

    rename_rrf i_rename_rrf (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .rs1_tag_i    (rs1_tag),
        .rs2_tag_i    (rs2_tag),
        .rs1_data_o   (rs1_rrf_data),
        .rs2_data_o   (rs2_rrf_data),
        .rs1_valid_o  (rs1_rrf_valid),
        .rs2_valid_o  (rs2_rrf_valid),
        .wb_i         (wb_i),
        .alloc_en_i   (alloc_en),
        .alloc_tag_i  (alloc_tag),
        .commit_tag_i (commit_i.tag),
        .commit_data_o(commit_data)
    );

    rrf_alloc i_rrf_alloc (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .alloc_en_i (alloc_en),
        .free_en_i  (commit_i.valid),
        .alloc_tag_o(alloc_tag),
        .free_num_o (free_num_o),
        .stall_o    (stall_o)
    );

    src_resolve i_src1_resolve (
        .rs_i       (req_i.rs1),
        .arf_busy_i (rs1_busy),
        .arf_data_i (rs1_arf_data),
        .arf_tag_i  (rs1_tag),
        .rrf_valid_i(rs1_rrf_valid),
        .rrf_data_i (rs1_rrf_data),
        .opnd_o     (src1)
    );

    src_resolve i_src2_resolve (
        .rs_i       (req_i.rs2),
        .arf_busy_i (rs2_busy),
        .arf_data_i (rs2_arf_data),
        .arf_tag_i  (rs2_tag),
        .rrf_valid_i(rs2_rrf_valid),
        .rrf_data_i (rs2_rrf_data),
        .opnd_o     (src2)
    );

    // one cycle output stage
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rsp_q.valid <= 1'b0;
        end else begin
            rsp_q.valid <= accept;
        end
        if (accept) begin
            rsp_q.dst_en  <= req_i.dst_en;
            rsp_q.dst_tag <= alloc_tag;
            rsp_q.src1    <= src1;
            rsp_q.src2    <= src2;
        end
    end

    assign rsp_o     = rsp_q;
    assign rrf_ptr_o = alloc_tag;

endmodule

`default_nettype wire

/* bench/rename_props.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module rename_props (
    input wire                          clk_i,
    input wire                          reset_i,
    input wire rename_pkg::rename_req_t req_i,
    input wire rename_pkg::rename_rsp_t rsp_i,
    input wire                          stall_i,
    input wire [`RN_RRF_SEL:0]          free_num_i
);

    // stall only when nothing is left to hand out
    a_stall_empty: assert property (
        @(posedge clk_i) disable iff (reset_i) stall_i |-> (free_num_i == '0)
    ) else $error("stall_o high while rename entries are free");

    a_free_bound: assert property (
        @(posedge clk_i) disable iff (reset_i)
        free_num_i <= (`RN_RRF_SEL+1)'(`RN_RRF_NUM)
    ) else $error("free_num_o above the rename file depth");

    a_idle_after_reset: assert property (
        @(posedge clk_i) reset_i |=> !rsp_i.valid
    ) else $error("rsp_o.valid high in the cycle after reset");

    // one cycle from acceptance to response
    a_rsp_has_req: assert property (
        @(posedge clk_i) disable iff (reset_i)
        rsp_i.valid |-> $past(req_i.valid && !stall_i)
    ) else $error("response without an accepted request one cycle before");

endmodule

`default_nettype wire

/* bench/tb_rename_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rename_macros.svh"

module tb_rename_unit;

    localparam int N_CYCLES    = 4000;
    localparam int WATCHDOG_NS = (N_CYCLES + 2) * 10 + 2000;

    logic clk_i = 1'b0;
    logic reset_i;

    rename_pkg::rename_req_t                 req_i;
    rename_pkg::wb_port_t [`RN_WB_PORTS-1:0] wb_i;
    rename_pkg::commit_t                     commit_i;
    rename_pkg::rename_rsp_t                 rsp_o;
    logic                                    stall_o;
    logic [`RN_RRF_SEL:0]                    free_num_o;
    logic [`RN_RRF_SEL-1:0]                  rrf_ptr_o;

    // reference model state, as it stands after the last clock edge
    logic [`RN_DATA_LEN-1:0]  m_arf_data [`RN_ARCH_REGS];
    logic [`RN_RRF_SEL-1:0]   m_arf_tag  [`RN_ARCH_REGS];
    logic [`RN_ARCH_REGS-1:0] m_arf_busy;
    logic [`RN_DATA_LEN-1:0]  m_rrf_data [`RN_RRF_NUM];
    logic [`RN_RRF_NUM-1:0]   m_rrf_valid;
    logic [`RN_RRF_NUM-1:0]   wb_done;
    logic [`RN_RRF_SEL-1:0]   m_ptr;
    int                       m_free;

    // rob view, oldest allocation first
    logic [`RN_RRF_SEL-1:0] alloc_tags [$];
    logic [`RN_REG_SEL-1:0] alloc_rds  [$];

    rename_pkg::rename_rsp_t exp_rsp;
    logic                    hold_req;
    logic                    saw_stall;
    logic                    saw_pend;
    int                      cyc;

    always #5 clk_i = ~clk_i;

    rename_unit i_rename_unit (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (req_i),
        .wb_i      (wb_i),
        .commit_i  (commit_i),
        .rsp_o     (rsp_o),
        .stall_o   (stall_o),
        .free_num_o(free_num_o),
        .rrf_ptr_o (rrf_ptr_o)
    );

    bind rename_unit rename_props i_rename_props (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .req_i     (req_i),
        .rsp_i     (rsp_o),
        .stall_i   (stall_o),
        .free_num_i(free_num_o)
    );

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure($sformatf("timeout: run did not finish within %0d ns", WATCHDOG_NS));
    end

    task automatic reset_model();
        for (int i = 0; i < `RN_ARCH_REGS; i++) begin
            m_arf_data[i] = '0;
            m_arf_tag[i]  = '0;
        end
        m_arf_busy  = '0;
        m_rrf_valid = '0;
        wb_done     = '0;
        m_ptr       = '0;
        m_free      = `RN_RRF_NUM;
        exp_rsp     = '0;
        hold_req    = 1'b0;
        saw_stall   = 1'b0;
        saw_pend    = 1'b0;
    endtask

    // low registers more often, so sources hit recent destinations
    function automatic logic [`RN_REG_SEL-1:0] pick_reg();
        if (($urandom % 2) == 0) begin
            return `RN_REG_SEL'($urandom % 8);
        end
        return `RN_REG_SEL'($urandom % `RN_ARCH_REGS);
    endfunction

    function automatic rename_pkg::operand_t resolve_src(input logic [`RN_REG_SEL-1:0] rs);
        rename_pkg::operand_t   op;
        logic [`RN_RRF_SEL-1:0] t;
        t = m_arf_tag[rs];
        op.ready = (rs == '0) || !m_arf_busy[rs] || m_rrf_valid[t];
        if (rs == '0) begin
            op.word.data = '0;
        end else if (!m_arf_busy[rs]) begin
            op.word.data = m_arf_data[rs];
        end else if (m_rrf_valid[t]) begin
            op.word.data = m_rrf_data[t];
        end else begin
            op.word.data = `RN_DATA_LEN'(t);
        end
        return op;
    endfunction

    task automatic drive_cycle();
        rename_pkg::rename_req_t                 req;
        rename_pkg::wb_port_t [`RN_WB_PORTS-1:0] wb;
        rename_pkg::commit_t                     cm;
        int                                      taken;
        int                                      idx;
        logic                                    hold_commits;
        hold_commits = (cyc % 200) >= 120;
        if (hold_req) begin
            req = req_i;
        end else begin
            req.valid  = ($urandom % 4) != 0;
            req.rs1    = pick_reg();
            req.rs2    = pick_reg();
            req.rd     = pick_reg();
            req.dst_en = ($urandom % 4) != 0;
        end
        wb    = '0;
        taken = -1;
        for (int p = 0; p < `RN_WB_PORTS; p++) begin
            if (alloc_tags.size() > 0 && ($urandom % 2) == 0) begin
                idx = int'($urandom % alloc_tags.size());
                if (!wb_done[alloc_tags[idx]] && idx != taken) begin
                    wb[p].valid = 1'b1;
                    wb[p].tag   = alloc_tags[idx];
                    wb[p].data  = $urandom;
                    taken       = idx;
                end
            end
        end
        cm = '0;
        if (!hold_commits && alloc_tags.size() > 0 && ($urandom % 3) != 0) begin
            if (wb_done[alloc_tags[0]]) begin
                cm.valid = 1'b1;
                cm.we    = 1'b1;
                cm.rd    = alloc_rds[0];
                cm.tag   = alloc_tags[0];
            end
        end
        req_i    <= req;
        wb_i     <= wb;
        commit_i <= cm;
    endtask

    task automatic check_outputs();
        if (stall_o === 1'b1) begin
            saw_stall = 1'b1;
        end
        assert (stall_o === (m_free == 0))
            else stop_with_failure($sformatf("ERR %0t: stall_o %b, free count %0d",
                                             $time, stall_o, m_free));
        assert (free_num_o === (`RN_RRF_SEL+1)'(m_free))
            else stop_with_failure($sformatf("ERR %0t: free_num_o %0d, expected %0d",
                                             $time, free_num_o, m_free));
        assert (rrf_ptr_o === m_ptr)
            else stop_with_failure($sformatf("ERR %0t: rrf_ptr_o %0d, expected %0d",
                                             $time, rrf_ptr_o, m_ptr));
        assert (rsp_o.valid === exp_rsp.valid)
            else stop_with_failure($sformatf("ERR %0t: rsp valid %b, expected %b",
                                             $time, rsp_o.valid, exp_rsp.valid));
        if (exp_rsp.valid) begin
            assert (rsp_o.dst_en === exp_rsp.dst_en)
                else stop_with_failure($sformatf("ERR %0t: dst_en %b, expected %b",
                                                 $time, rsp_o.dst_en, exp_rsp.dst_en));
            assert (!exp_rsp.dst_en || rsp_o.dst_tag === exp_rsp.dst_tag)
                else stop_with_failure($sformatf("ERR %0t: dst_tag %0d, expected %0d",
                                                 $time, rsp_o.dst_tag, exp_rsp.dst_tag));
            assert (rsp_o.src1 === exp_rsp.src1)
                else stop_with_failure($sformatf("ERR %0t: src1 %h, expected %h",
                                                 $time, rsp_o.src1, exp_rsp.src1));
            assert (rsp_o.src2 === exp_rsp.src2)
                else stop_with_failure($sformatf("ERR %0t: src2 %h, expected %h",
                                                 $time, rsp_o.src2, exp_rsp.src2));
        end
    endtask

    // next edge, with the inputs now on the bus
    task automatic advance_model();
        logic accept;
        accept   = req_i.valid && (m_free != 0);
        hold_req = req_i.valid && !accept;
        exp_rsp.valid = accept;
        if (accept) begin
            exp_rsp.dst_en  = req_i.dst_en;
            exp_rsp.dst_tag = m_ptr;
            exp_rsp.src1    = resolve_src(req_i.rs1);
            exp_rsp.src2    = resolve_src(req_i.rs2);
            if (!exp_rsp.src1.ready || !exp_rsp.src2.ready) begin
                saw_pend = 1'b1;
            end
        end
        if (commit_i.valid) begin
            if (commit_i.we && commit_i.rd != '0) begin
                m_arf_data[commit_i.rd] = m_rrf_data[commit_i.tag];
                if (m_arf_busy[commit_i.rd] && m_arf_tag[commit_i.rd] == commit_i.tag) begin
                    m_arf_busy[commit_i.rd] = 1'b0;
                end
            end
            m_free++;
            void'(alloc_tags.pop_front());
            void'(alloc_rds.pop_front());
        end
        for (int p = 0; p < `RN_WB_PORTS; p++) begin
            if (wb_i[p].valid) begin
                m_rrf_data[wb_i[p].tag]  = wb_i[p].data;
                m_rrf_valid[wb_i[p].tag] = 1'b1;
                wb_done[wb_i[p].tag]     = 1'b1;
            end
        end
        if (accept && req_i.dst_en) begin
            m_rrf_valid[m_ptr] = 1'b0;
            wb_done[m_ptr]     = 1'b0;
            if (req_i.rd != '0) begin
                m_arf_busy[req_i.rd] = 1'b1;
                m_arf_tag[req_i.rd]  = m_ptr;
            end
            alloc_tags.push_back(m_ptr);
            alloc_rds.push_back(req_i.rd);
            m_ptr = m_ptr + 1'b1;
            m_free--;
        end
    endtask

    initial begin
        void'($urandom(10676));
        reset_i  = 1'b1;
        req_i    = '0;
        wb_i     = '0;
        commit_i = '0;
        cyc      = 0;
        reset_model();
        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        assert (rsp_o.valid === 1'b0 && stall_o === 1'b0 && rrf_ptr_o === '0 &&
                free_num_o === (`RN_RRF_SEL+1)'(`RN_RRF_NUM))
            else stop_with_failure($sformatf("ERR %0t: outputs not idle after reset", $time));
        for (cyc = 0; cyc < N_CYCLES; cyc++) begin
            @(posedge clk_i);
            drive_cycle();
            @(negedge clk_i);
            check_outputs();
            advance_model();
        end
        assert (saw_stall)
            else stop_with_failure("the rename file never filled up, stall_o was never seen");
        assert (saw_pend)
            else stop_with_failure("no source operand was ever left waiting on a tag");
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
common/rename_pkg.sv
rename/rename_arf.sv
rename/rename_rrf.sv
rename/rrf_alloc.sv
rename/src_resolve.sv
rename/rename_unit.sv
bench/rename_props.sv
bench/tb_rename_unit.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_rename_unit -f verilog.f \
    && ./obj_dir/Vtb_rename_unit > sim.log 2>&1 \
    || echo "build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0
